/* include/control_bits.svh */
// ==============================
// Column codes
// ==============================

// One-hot column strobes from the CPU
localparam logic [7:0] col_0 = 8'h01;
localparam logic [7:0] col_1 = 8'h02;
localparam logic [7:0] col_2 = 8'h04;
localparam logic [7:0] col_3 = 8'h08;

// ==============================
// Joystick field bit positions
// ==============================

// Direction nibble sits in the same place in every button column
localparam int bit_up = 0;
localparam int bit_down = 1;
localparam int bit_left = 2;
localparam int bit_right = 3;

// Fire in Space Zap and Gorf
localparam int bit_fire_lo = 4;
// Fire in Wizard of Wor and Robby Roto
localparam int bit_fire_hi = 5;
// Wizard of Wor move shares the slot of the low fire bit
localparam int bit_move = 4;

/* design/astro_input_pkg.sv */
package astro_input_pkg;

	// ==============================
	// Widths with a meaning
	// ==============================

	// Signed stick axis as delivered by the host
	typedef logic [7:0] axis_raw_t;
	// Offset paddle value, centre at 128
	typedef logic [7:0] paddle_t;
	// Accumulated trackball position
	typedef logic [7:0] track_pos_t;
	// Switch-matrix column word, switches active low
	typedef logic [7:0] row_word_t;
	// One-hot column code from the CPU
	typedef logic [7:0] col_sel_t;

	// Game selection held in the configuration register
	typedef enum logic [2:0] {
		game_none,
		game_ebases,
		game_spacezap,
		game_wow,
		game_gorf,
		game_robby
	} game_t;

	// ==============================
	// Grouped signals
	// ==============================

	// Both analog sticks, one signed byte per axis
	typedef struct packed {
		axis_raw_t p1_x;
		axis_raw_t p1_y;
		axis_raw_t p2_x;
		axis_raw_t p2_y;
	} sticks_t;

	// Digital controls of one player, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic move;
		logic start;
	} buttons_t;

	// Game selection plus the DIP bytes the games read
	typedef struct packed {
		game_t     game;
		logic [7:0] dip0;
		logic [7:0] dip2;
		logic [7:0] dip3;
	} game_cfg_t;

	// Decoded flags and trackball count of one axis
	typedef struct packed {
		logic       dir_lo;
		logic       dir_hi;
		logic       move;
		track_pos_t pos;
	} axis_state_t;

	// Column read request, track_sel only matters for Extra Bases
	typedef struct packed {
		col_sel_t   col;
		logic [1:0] track_sel;
	} rd_req_t;

	// ==============================
	// Constants
	// ==============================

	localparam int num_axes = 4;
	localparam paddle_t paddle_centre = 8'd128;
	// Word returned for a column no game drives
	localparam row_word_t row_idle = 8'hff;

	// Axis order in the paddle and decoder arrays
	localparam int axis_p1_x = 0;
	localparam int axis_p1_y = 1;
	localparam int axis_p2_x = 2;
	localparam int axis_p2_y = 3;

	// Top three paddle bits that raise direction flags
	localparam logic [2:0] band_lo_move = 3'd0;
	localparam logic [2:0] band_lo = 3'd1;
	localparam logic [2:0] band_hi = 3'd6;
	localparam logic [2:0] band_hi_move = 3'd7;

	// Top four paddle bits of a centred stick, zero trackball step
	localparam logic [3:0] track_rest = 4'd8;

endpackage

/* design/stick_front.sv */
module stick_front import astro_input_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  sticks_t sticks,
	input  logic    sample_tick,
	output paddle_t paddle [num_axes],
	output logic    paddle_valid
);

	// Stick axes laid out in decoder order
	axis_raw_t raw [num_axes];

	assign raw[axis_p1_x] = sticks.p1_x;
	assign raw[axis_p1_y] = sticks.p1_y;
	assign raw[axis_p2_x] = sticks.p2_x;
	assign raw[axis_p2_y] = sticks.p2_y;

	// ==============================
	// Sample strobe
	// ==============================

	// Fresh sample marker, one cycle behind the tick
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			paddle_valid <= 1'b0;
		end else begin
			paddle_valid <= sample_tick;
		end
	end

	// ==============================
	// Offset conversion
	// ==============================

	// Signed axis to offset paddle
	// Y axes inverted first so stick-up reads high
	always_ff @(posedge clk_sys) begin
		if (sample_tick) begin
			for (int i = 0; i < num_axes; i++) begin
				if (i == axis_p1_y || i == axis_p2_y) begin
					paddle[i] <= ~raw[i] + paddle_centre;
				end else begin
					paddle[i] <= raw[i] + paddle_centre;
				end
			end
		end
	end

	// Paddle values hold between ticks
	// Decoders only look at them when paddle_valid is set

endmodule

/* design/axis_decoder.sv */
module axis_decoder import astro_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  paddle_t     paddle,
	input  logic        paddle_valid,
	output axis_state_t state
);

	// Coarse position bands of the paddle value
	logic [2:0] band;
	logic [3:0] coarse;

	// Signed trackball step and its 8-bit extension
	logic [3:0] step;
	track_pos_t step_ext;

	// Next flag values
	logic dir_lo_nxt;
	logic dir_hi_nxt;
	logic move_nxt;

	assign band = paddle[7:5];
	assign coarse = paddle[7:4];

	// Centre band gives zero, ends give -8 and +7
	assign step = coarse - track_rest;
	assign step_ext = {{4{step[3]}}, step};

	// ==============================
	// Direction and move decode
	// ==============================

	// Outer bands also raise move
	// Middle four bands are a dead zone
	always_comb begin
		dir_lo_nxt = 1'b0;
		dir_hi_nxt = 1'b0;
		move_nxt = 1'b0;
		case (band)
			band_lo_move: begin
				dir_lo_nxt = 1'b1;
				move_nxt = 1'b1;
			end
			band_lo: begin
				dir_lo_nxt = 1'b1;
			end
			band_hi: begin
				dir_hi_nxt = 1'b1;
			end
			band_hi_move: begin
				dir_hi_nxt = 1'b1;
				move_nxt = 1'b1;
			end
			default: begin
				move_nxt = 1'b0;
			end
		endcase
	end

	// ==============================
	// Registered outputs
	// ==============================

	// Flags follow the newest sample
	// pos wraps modulo 256, like a free-running trackball counter
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= '0;
		end else if (paddle_valid) begin
			state.dir_lo <= dir_lo_nxt;
			state.dir_hi <= dir_hi_nxt;
			state.move <= move_nxt;
			state.pos <= state.pos + step_ext;
		end
	end

	// Flags only move on the cycle after a fresh sample from the front
	flags_paced: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(paddle_valid) |-> $stable({state.dir_lo, state.dir_hi}));

endmodule

/* design/switch_matrix.sv */
module switch_matrix import astro_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  game_cfg_t   cfg,
	input  logic        cfg_load,
	input  axis_state_t axes [num_axes],
	input  buttons_t    p1_buttons,
	input  buttons_t    p2_buttons,
	input  logic        coin,
	input  logic        rd_req,
	input  rd_req_t     rd,
	output logic        rd_ack,
	output row_word_t   row
);

	`include "control_bits.svh"

	// Read handshake states
	typedef enum logic [1:0] {
		st_idle,
		st_ack,
		st_release
	} ack_state_t;

	game_cfg_t cfg_q;
	ack_state_t ack_state;
	logic req_q;

	// Wizard of Wor controls after the stick/button choice
	buttons_t wow_p1;
	buttons_t wow_p2;
	logic wow_mv1;
	logic wow_mv2;

	// Column words of the selected game
	row_word_t w0;
	row_word_t w1;
	row_word_t w2;
	track_pos_t track_word;
	row_word_t col_word;

	// Active-low joystick field, fire placed per game
	function automatic row_word_t pad_word(row_word_t base, buttons_t b, int fire_pos);
		row_word_t w;
		w = base;
		w[bit_up] = ~b.up;
		w[bit_down] = ~b.down;
		w[bit_left] = ~b.left;
		w[bit_right] = ~b.right;
		w[fire_pos] = ~b.fire;
		return w;
	endfunction

	// Wizard of Wor column with its move bit
	function automatic row_word_t wow_word(row_word_t base, buttons_t b, logic mv);
		row_word_t w;
		w = pad_word(base, b, bit_fire_hi);
		w[bit_move] = mv;
		return w;
	endfunction

	// Axis flags standing in for the digital directions
	function automatic buttons_t stick_dirs(buttons_t b, axis_state_t ax, axis_state_t ay);
		buttons_t s;
		s = b;
		s.up = ay.dir_hi;
		s.down = ay.dir_lo;
		s.left = ax.dir_lo;
		s.right = ax.dir_hi;
		return s;
	endfunction

	// ==============================
	// Configuration register
	// ==============================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg_q.game <= game_none;
			cfg_q.dip0 <= '0;
			cfg_q.dip2 <= '0;
			cfg_q.dip3 <= '0;
		end else if (cfg_load) begin
			cfg_q <= cfg;
		end
	end

	// ==============================
	// Column word assembly
	// ==============================

	// Stick mode per player, move goes active low with the stick
	assign wow_p1 = cfg_q.dip0[0] ? stick_dirs(p1_buttons, axes[axis_p1_x], axes[axis_p1_y])
		: p1_buttons;
	assign wow_p2 = cfg_q.dip0[1] ? stick_dirs(p2_buttons, axes[axis_p2_x], axes[axis_p2_y])
		: p2_buttons;
	assign wow_mv1 = cfg_q.dip0[0] ? ~(axes[axis_p1_x].move | axes[axis_p1_y].move)
		: p1_buttons.move;
	assign wow_mv2 = cfg_q.dip0[1] ? ~(axes[axis_p2_x].move | axes[axis_p2_y].move)
		: p2_buttons.move;

	// Extra Bases trackball, bit 1 picks player, bit 0 picks horizontal
	always_comb begin
		case (rd.track_sel)
			2'b00: track_word = axes[axis_p1_y].pos;
			2'b01: track_word = axes[axis_p1_x].pos;
			2'b10: track_word = axes[axis_p2_y].pos;
			default: track_word = axes[axis_p2_x].pos;
		endcase
	end

	// Columns 0 to 2 per game, bit 7 of some words is the speech busy flag, tied low
	always_comb begin
		w0 = row_idle;
		w1 = row_idle;
		w2 = row_idle;
		case (cfg_q.game)
			game_ebases: begin
				w0 = {2'b11, ~p2_buttons.start, ~p1_buttons.start, 2'b11,
					~p1_buttons.fire, ~p2_buttons.fire};
				w1 = {1'b1, cfg_q.dip0[1], 1'b1, cfg_q.dip0[1], 3'b111, ~coin};
				w2 = cfg_q.dip2;
			end
			game_spacezap: begin
				w0 = {2'b11, ~p2_buttons.start, ~p1_buttons.start, cfg_q.dip2[1], 1'b1,
					~coin, 1'b1};
				w1 = pad_word(8'he0, p2_buttons, bit_fire_lo);
				w2 = pad_word({2'b11, cfg_q.dip2[0], 5'b0}, p1_buttons, bit_fire_lo);
			end
			game_wow: begin
				w0 = {cfg_q.dip2[2], ~p2_buttons.start, ~p1_buttons.start, 1'b1,
					cfg_q.dip2[1], 1'b1, ~coin, 1'b1};
				w1 = wow_word(8'hc0, wow_p2, wow_mv2);
				w2 = wow_word(8'h40, wow_p1, wow_mv1);
			end
			game_gorf: begin
				w0 = {cfg_q.dip2[2], cfg_q.dip2[0], ~p2_buttons.start, ~p1_buttons.start,
					1'b1, cfg_q.dip2[1], ~coin, 1'b1};
				w1 = pad_word(8'h20, p2_buttons, bit_fire_lo);
				w2 = pad_word(8'h20, p1_buttons, bit_fire_lo);
			end
			game_robby: begin
				w0 = {1'b0, ~p2_buttons.start, ~p1_buttons.start, 1'b1, cfg_q.dip2[1],
					1'b1, ~coin, 1'b1};
				w1 = pad_word(8'hf0, p2_buttons, bit_fire_hi);
				w2 = pad_word(8'hf0, p1_buttons, bit_fire_hi);
			end
			default: begin
				w0 = row_idle;
			end
		endcase
	end

	// Column select, col3 is the trackball on Extra Bases and dip3 elsewhere
	always_comb begin
		case (rd.col)
			col_0: col_word = w0;
			col_1: col_word = w1;
			col_2: col_word = w2;
			col_3: begin
				if (cfg_q.game == game_none) begin
					col_word = row_idle;
				end else if (cfg_q.game == game_ebases) begin
					col_word = track_word;
				end else begin
					col_word = cfg_q.dip3;
				end
			end
			default: col_word = row_idle;
		endcase
	end

	// ==============================
	// Four-phase read port
	// ==============================

	// Request registered first, ack one cycle later
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			req_q <= 1'b0;
			ack_state <= st_idle;
		end else begin
			req_q <= rd_req;
			case (ack_state)
				st_idle: if (req_q) ack_state <= st_ack;
				st_ack: if (!req_q) ack_state <= st_release;
				st_release: ack_state <= st_idle;
				default: ack_state <= st_idle;
			endcase
		end
	end

	// Row frozen at the ack edge, later ticks leave it alone
	always_ff @(posedge clk_sys) begin
		if (ack_state == st_idle && req_q) begin
			row <= col_word;
		end
	end

	assign rd_ack = (ack_state == st_ack);

	// Requester holds the column steady for the whole request
	rd_held: assert property (@(posedge clk_sys) disable iff (reset)
		rd_req && $past(rd_req) |-> $stable(rd));

	// Ack only answers a request that was already up
	ack_answers: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(rd_ack) |-> $past(rd_req));

endmodule

/* design/astro_input_top.sv */
module astro_input_top import astro_input_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  game_cfg_t cfg,
	input  logic      cfg_load,
	input  sticks_t   sticks,
	input  buttons_t  p1_buttons,
	input  buttons_t  p2_buttons,
	input  logic      coin,
	input  logic      sample_tick,
	input  logic      rd_req,
	input  rd_req_t   rd,
	output logic      rd_ack,
	output row_word_t row
);

	// Offset paddles shared by all decoders
	paddle_t paddle [num_axes];
	logic paddle_valid;
	// Per-axis flags and trackball counts
	axis_state_t axes [num_axes];

	// ==============================
	// Stick sampling
	// ==============================

	stick_front i_front (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sticks       (sticks),
		.sample_tick  (sample_tick),
		.paddle       (paddle),
		.paddle_valid (paddle_valid)
	);

	// One decoder per axis, same order as the paddle array
	for (genvar i = 0; i < num_axes; i++) begin : g_axis
		axis_decoder i_axis (
			.clk_sys      (clk_sys),
			.reset        (reset),
			.paddle       (paddle[i]),
			.paddle_valid (paddle_valid),
			.state        (axes[i])
		);
	end

	// ==============================
	// Column words and read port
	// ==============================

	switch_matrix i_matrix (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg        (cfg),
		.cfg_load   (cfg_load),
		.axes       (axes),
		.p1_buttons (p1_buttons),
		.p2_buttons (p2_buttons),
		.coin       (coin),
		.rd_req     (rd_req),
		.rd         (rd),
		.rd_ack     (rd_ack),
		.row        (row)
	);

endmodule

/* tests/tb_astro_input.sv */
module tb_astro_input import astro_input_pkg::*; ();

	`include "control_bits.svh"

	// Stimulus record layout, one opcode byte then nine field bytes
	localparam int rec_len = 10;
	localparam int script_depth = 1024;
	// Cycles a handshake edge may take before the run gives up
	localparam int ack_limit = 50;

	logic clk_sys;
	logic reset;
	game_cfg_t cfg;
	logic cfg_load;
	sticks_t sticks;
	buttons_t p1_buttons;
	buttons_t p2_buttons;
	logic coin;
	logic sample_tick;
	logic rd_req;
	rd_req_t rd;
	logic rd_ack;
	row_word_t row;

	logic [7:0] script [0:script_depth-1];

	int value_errs;
	int timeout_errs;
	int script_errs;

	astro_input_top i_astro_input_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cfg         (cfg),
		.cfg_load    (cfg_load),
		.sticks      (sticks),
		.p1_buttons  (p1_buttons),
		.p2_buttons  (p2_buttons),
		.coin        (coin),
		.sample_tick (sample_tick),
		.rd_req      (rd_req),
		.rd          (rd),
		.rd_ack      (rd_ack),
		.row         (row)
	);

	// 40 unit period
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ==============================
	// Compare tasks
	// ==============================

	task automatic check_row(input row_word_t got, input row_word_t exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s, row %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s, level %b expected %b", $time, what, got, exp);
		end
	endtask

	// ==============================
	// Stimulus helpers
	// ==============================

	// Column number from the file to the one-hot CPU strobe
	function automatic col_sel_t col_code(input logic [7:0] num);
		case (num)
			8'd0: return col_0;
			8'd1: return col_1;
			8'd2: return col_2;
			8'd3: return col_3;
			default: return 8'h01 << num[2:0];
		endcase
	endfunction

	// Tick strobes, each followed by time for front and decoder to settle
	task automatic pulse_tick(input logic [7:0] count);
		repeat (count) begin
			sample_tick = 1'b1;
			@(negedge clk_sys);
			sample_tick = 1'b0;
			repeat (3) @(negedge clk_sys);
		end
	endtask

	task automatic set_axis(input logic [7:0] axis, input axis_raw_t raw);
		case (axis)
			8'd0: sticks.p1_x = raw;
			8'd1: sticks.p1_y = raw;
			8'd2: sticks.p2_x = raw;
			default: sticks.p2_y = raw;
		endcase
	endtask

	// Full four-phase read, optionally with a stick change and tick while held
	task automatic read_column(input logic [7:0] col_num, input logic [1:0] sel,
		input row_word_t exp, input logic [7:0] hold, input logic with_tick,
		input logic [7:0] axis, input axis_raw_t raw, output bit ok);
		int n;
		string what;
		ok = 1'b1;
		what = $sformatf("column %0d track_sel %0d", col_num, sel);
		rd.col = col_code(col_num);
		rd.track_sel = sel;
		rd_req = 1'b1;
		n = 0;
		@(negedge clk_sys);
		while (rd_ack !== 1'b1 && n < ack_limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (rd_ack !== 1'b1) begin
			$display("Timeout: rd_ack never rose for a read of %s", what);
			timeout_errs++;
			ok = 1'b0;
			return;
		end
		check_row(row, exp, what);
		if (with_tick) begin
			set_axis(axis, raw);
			pulse_tick(8'd1);
		end
		repeat (hold) begin
			@(negedge clk_sys);
			check_level(rd_ack, 1'b1, {"rd_ack held during ", what});
		end
		// Latched row must survive the hold and any tick inside it
		check_row(row, exp, {what, " after hold"});
		rd_req = 1'b0;
		@(negedge clk_sys);
		// Ack still up in the cycle the low request is first registered
		check_level(rd_ack, 1'b1, {"rd_ack one cycle after release of ", what});
		n = 0;
		while (rd_ack !== 1'b0 && n < ack_limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (rd_ack !== 1'b0) begin
			$display("Timeout: rd_ack stayed high after the request for %s dropped", what);
			timeout_errs++;
			ok = 1'b0;
		end
	endtask

	task automatic report_and_finish();
		$display("Errors: %0d value mismatches, %0d timeouts, %0d stimulus file problems",
			value_errs, timeout_errs, script_errs);
		if (value_errs + timeout_errs + script_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin : run
		int addr;
		logic [7:0] op;
		logic [7:0] fld [0:rec_len-2];
		bit running;
		bit ok;
		reset = 1'b1;
		cfg = '0;
		cfg_load = 1'b0;
		sticks = '0;
		p1_buttons = '0;
		p2_buttons = '0;
		coin = 1'b0;
		sample_tick = 1'b0;
		rd_req = 1'b0;
		rd = '0;
		value_errs = 0;
		timeout_errs = 0;
		script_errs = 0;
		$readmemh("tests/input_tests.txt", script);
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		addr = 0;
		running = 1'b1;
		while (running) begin
			if (addr + rec_len > script_depth) begin
				$display("Stimulus file has no end record within %0d bytes", script_depth);
				script_errs++;
				running = 1'b0;
			end else begin
				op = script[addr];
				for (int i = 0; i < rec_len - 1; i++) begin
					fld[i] = script[addr + 1 + i];
				end
				case (op)
					8'h00: running = 1'b0;
					// Config load, one-cycle strobe
					8'h01: begin
						cfg.game = game_t'(fld[0][2:0]);
						cfg.dip0 = fld[1];
						cfg.dip2 = fld[2];
						cfg.dip3 = fld[3];
						cfg_load = 1'b1;
						@(negedge clk_sys);
						cfg_load = 1'b0;
					end
					// Sticks, buttons and coin, then ticks
					8'h02: begin
						sticks = {fld[0], fld[1], fld[2], fld[3]};
						p1_buttons = fld[4][6:0];
						p2_buttons = fld[5][6:0];
						coin = fld[6][0];
						pulse_tick(fld[7]);
					end
					8'h03: begin
						read_column(fld[0], fld[1][1:0], fld[2], fld[3], 1'b0, 8'h00,
							8'h00, ok);
						running = ok;
					end
					8'h04: begin
						read_column(fld[0], fld[1][1:0], fld[2], fld[3], 1'b1, fld[4],
							fld[5], ok);
						running = ok;
					end
					default: begin
						$display("Unknown opcode %02h in record %0d of the stimulus file",
							op, addr / rec_len);
						script_errs++;
						running = 1'b0;
					end
				endcase
				addr = addr + rec_len;
			end
		end
		report_and_finish();
	end

endmodule

/* tests/input_tests.txt */
// Ten hex bytes per record: opcode, then fields, unused fields 00
// 01 config: game dip0 dip2 dip3 | 02 drive: p1x p1y p2x p2y p1btn p2btn coin ticks
// 03 read: col track_sel expected hold | 04 held read: col sel expected hold axis raw | 00 end
// Reset state, no game selected
03 00 00 ff 00 00 00 00 00 00
03 01 00 ff 00 00 00 00 00 00
03 02 00 ff 03 00 00 00 00 00
03 03 00 ff 00 00 00 00 00 00
03 05 00 ff 00 00 00 00 00 00
01 00 a5 5a c3 00 00 00 00 00
03 00 00 ff 00 00 00 00 00 00
03 03 00 ff 00 00 00 00 00 00
// Space Zap
01 02 00 03 5a 00 00 00 00 00
02 00 00 00 00 45 28 01 00 00
03 00 00 ed 00 00 00 00 00 00
03 01 00 f5 00 00 00 00 00 00
03 02 00 ee 00 00 00 00 00 00
03 03 00 5a 00 00 00 00 00 00
03 05 00 ff 00 00 00 00 00 00
// Gorf
01 04 00 05 3c 00 00 00 00 00
03 00 00 e9 00 00 00 00 00 00
03 01 00 35 00 00 00 00 00 00
03 02 00 2e 00 00 00 00 00 00
03 03 00 3c 00 00 00 00 00 00
03 06 00 ff 00 00 00 00 00 00
// Robby Roto
01 05 00 02 81 00 00 00 00 00
02 00 00 00 00 14 45 00 00 00
03 00 00 3f 00 00 00 00 00 00
03 01 00 de 00 00 00 00 00 00
03 02 00 db 00 00 00 00 00 00
03 03 00 81 00 00 00 00 00 00
// Wizard of Wor, player 1 on the stick, one band per tick
01 03 01 06 00 00 00 00 00 00
02 80 00 00 00 45 12 01 01 00
03 00 00 dd 00 00 00 00 00 00
03 01 00 fb 00 00 00 00 00 00
03 02 00 4b 00 00 00 00 00 00
02 a0 40 00 00 45 12 01 01 00
03 02 00 59 00 00 00 00 00 00
02 00 b0 00 00 45 12 01 01 00
03 02 00 5e 00 00 00 00 00 00
02 50 80 00 00 45 12 01 01 00
03 02 00 46 00 00 00 00 00 00
02 7f 7f 00 00 45 12 01 01 00
03 02 00 45 00 00 00 00 00 00
// Wizard of Wor, back to the digital buttons
01 03 00 06 00 00 00 00 00 00
03 02 00 4e 00 00 00 00 00 00
// Extra Bases, trackball counts carry the earlier ticks
01 01 02 77 00 00 00 00 00 00
02 30 30 e0 d0 04 01 01 04 00
03 00 00 dd 00 00 00 00 00 00
03 01 00 fe 00 00 00 00 00 00
03 02 00 77 00 00 00 00 00 00
03 03 00 ed 00 00 00 00 00 00
03 03 01 0a 00 00 00 00 00 00
03 03 02 03 00 00 00 00 00 00
03 03 03 f8 00 00 00 00 00 00
02 30 30 e0 d0 04 01 01 02 00
03 03 01 10 00 00 00 00 00 00
03 03 02 07 00 00 00 00 00 00
// Long held read with a tick inside, then the new counts
04 03 01 10 14 00 70 00 00 00
03 03 01 17 00 00 00 00 00 00
03 03 03 f2 00 00 00 00 00 00
03 03 00 e1 00 00 00 00 00 00
03 03 02 09 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00

/* compile.f */
+incdir+include
design/astro_input_pkg.sv
design/stick_front.sv
design/axis_decoder.sv
design/switch_matrix.sv
design/astro_input_top.sv
tests/tb_astro_input.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the input front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module tb_astro_input \
	-o tb_astro_input

sim_output=$(./obj_dir/tb_astro_input)
echo "$sim_output"

if grep -qx "TEST PASS" <<< "$sim_output"; then
	exit 0
else
	echo "Simulation did not report a pass"
	exit 1
fi
